//--- hdl/egress_credit_gate.sv
// #########################################################
// egress credit gate: spends a credit per narrow flit and
// registers the flit onto the output.
// #########################################################
module egress_credit_gate #(
    parameter int OUT_CREDITS = 4
) (
     input  logic clk
    ,input  logic rst

    ,input  logic                         fifo_empty
    ,input  noc_narrow_pkg::narrow_flit_t fifo_head
    ,output logic                         fifo_pop

    ,input  logic                         out_credit
    ,output logic                         out_val
    ,output noc_narrow_pkg::narrow_flit_t out_data
);
    localparam int CNT_W = $clog2(OUT_CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;

    assign fifo_pop = !fifo_empty && (credit_cnt != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= CNT_W'(OUT_CREDITS);
            out_val    <= 1'b0;
        end else begin
            out_val <= fifo_pop;
            case ({fifo_pop, out_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt; // send and return cancel.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            out_data <= fifo_head;
        end
    end

endmodule

//--- hdl/flit_fifo.sv
// #########################################################
// first-word-fall-through fifo, stored type set by
// parameter. head shows the oldest entry combinationally.
// #########################################################
module flit_fifo #(
    parameter type flit_t = logic,
    parameter int  DEPTH  = 4
) (
     input  logic  clk
    ,input  logic  rst

    ,input  logic  push
    ,input  flit_t wdata
    ,input  logic  pop

    ,output flit_t head
    ,output logic  empty
    ,output logic  full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    flit_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));
    assign head  = mem[rd_ptr];

    // storage only, no reset.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither.
            endcase
        end
    end

endmodule

//--- hdl/hdr_flit_slicer.sv
// #########################################################
// header slicer: keeps the wide header and muxes out the
// routing, misc and extra narrow flits.
// #########################################################
module hdr_flit_slicer #(
    parameter int EXTRA_W = 96
) (
     input  logic clk

    ,input  logic                              hdr_load
    ,input  noc_narrow_pkg::wide_flit_t        wide_head
    ,input  noc_narrow_pkg::flit_sel_e         flit_sel
    ,input  logic [noc_narrow_pkg::extra_idx_w(EXTRA_W)-1:0] extra_index

    ,output noc_narrow_pkg::narrow_flit_t      narrow_flit
);
    localparam int NARROW_W  = noc_narrow_pkg::NARROW_W;
    localparam int N_EXTRA   = noc_narrow_pkg::extra_flit_count(EXTRA_W);
    localparam int PAD_W     = N_EXTRA * NARROW_W - EXTRA_W;
    localparam int EXTRA_MSB = noc_narrow_pkg::WIDE_W - noc_narrow_pkg::BASE_FLIT_W - 1;
    localparam int SRC_W     = noc_narrow_pkg::SRC_FIELDS_W;

    logic [SRC_W-1:0]                   src_reg;
    logic [EXTRA_W-1:0]                 extra_reg;
    logic [N_EXTRA-1:0][NARROW_W-1:0]   extra_padded;
    noc_narrow_pkg::narrow_flit_t       route_flit;
    noc_narrow_pkg::narrow_flit_t       misc_flit;

    // payload registers, loaded with the header pop.
    always_ff @(posedge clk) begin
        if (hdr_load) begin
            src_reg <= {wide_head[noc_narrow_pkg::SRC_CHIP_ID_MSB -: noc_narrow_pkg::SRC_CHIP_ID_W],
                        wide_head[noc_narrow_pkg::SRC_X_MSB -: noc_narrow_pkg::SRC_X_W],
                        wide_head[noc_narrow_pkg::SRC_Y_MSB -: noc_narrow_pkg::SRC_Y_W],
                        wide_head[noc_narrow_pkg::SRC_FBITS_MSB -: noc_narrow_pkg::SRC_FBITS_W]};
            extra_reg <= wide_head[EXTRA_MSB -: EXTRA_W];
        end
    end

    generate
        if (PAD_W == 0) begin : g_no_pad
            assign extra_padded = extra_reg;
        end else begin : g_pad
            assign extra_padded = {extra_reg, {PAD_W{1'b0}}}; // zeros at the low end.
        end
    endgenerate

    // routing flit straight off the fifo head so it is ready on load.
    always_comb begin
        route_flit = wide_head[noc_narrow_pkg::WIDE_W-1 -: NARROW_W];
        route_flit[noc_narrow_pkg::MSG_LEN_MSB -: noc_narrow_pkg::MSG_LEN_W] =
            noc_narrow_pkg::MSG_LEN_W'(N_EXTRA + 1); // misc flit plus extras.
    end

    always_comb begin
        misc_flit = '0; // metadata flit count stays zero.
        misc_flit[noc_narrow_pkg::MISC_SRC_MSB -: SRC_W] = src_reg;
    end

    always_comb begin
        case (flit_sel)
            noc_narrow_pkg::sel_route: narrow_flit = route_flit;
            noc_narrow_pkg::sel_misc:  narrow_flit = misc_flit;
            default:                   narrow_flit = extra_padded[extra_index];
        endcase
    end

endmodule

//--- hdl/narrow_flit_ctrl.sv
// #########################################################
// sequencing FSM: one routing, one misc, then the extra
// flits of each wide header, one per cycle while space.
// #########################################################
module narrow_flit_ctrl #(
    parameter int EXTRA_W = 96
) (
     input  logic clk
    ,input  logic rst

    ,input  logic in_empty
    ,input  logic out_full

    ,output logic in_pop
    ,output logic out_push
    ,output logic hdr_load
    ,output noc_narrow_pkg::flit_sel_e flit_sel
    ,output logic [noc_narrow_pkg::extra_idx_w(EXTRA_W)-1:0] extra_index
);
    localparam int N_EXTRA = noc_narrow_pkg::extra_flit_count(EXTRA_W);
    localparam int IDX_W   = noc_narrow_pkg::extra_idx_w(EXTRA_W);

    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_misc  = 2'd1,
        st_extra = 2'd2
    } state_e;

    state_e           state;
    state_e           state_next;
    logic [IDX_W-1:0] idx_next;
    logic             start;

    // routing flit goes out in the same cycle the header is taken.
    assign start = (state == st_idle) && !in_empty && !out_full;

    assign in_pop   = start;
    assign hdr_load = start;

    always_comb begin
        state_next = state;
        idx_next   = extra_index;
        out_push   = 1'b0;
        flit_sel   = noc_narrow_pkg::sel_route;

        case (state)
            st_idle: begin
                if (start) begin
                    out_push   = 1'b1;
                    idx_next   = IDX_W'(N_EXTRA - 1); // highest part first.
                    state_next = st_misc;
                end
            end
            st_misc: begin
                flit_sel = noc_narrow_pkg::sel_misc;
                if (!out_full) begin
                    out_push   = 1'b1;
                    state_next = st_extra;
                end
            end
            st_extra: begin
                flit_sel = noc_narrow_pkg::sel_extra;
                if (!out_full) begin
                    out_push = 1'b1;
                    if (extra_index == '0) begin
                        state_next = st_idle;
                    end else begin
                        idx_next = extra_index - 1'b1;
                    end
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_idle;
            extra_index <= '0;
        end else begin
            state       <= state_next;
            extra_index <= idx_next;
        end
    end

endmodule

//--- hdl/noc_narrow_pkg.sv
// #########################################################
// noc narrowing package: flit widths, wide header field
// positions, flit select type and extra flit sizing.
// #########################################################
package noc_narrow_pkg;

    localparam int WIDE_W      = 256;
    localparam int NARROW_W    = 64;
    localparam int BASE_FLIT_W = 128; // routing header plus source block.

    typedef logic [WIDE_W-1:0]   wide_flit_t;
    typedef logic [NARROW_W-1:0] narrow_flit_t;

    // routing header, positions within the routing flit.
    // the same fields sit 192 bits higher in a wide flit.
    localparam int DST_CHIP_ID_MSB = 63;
    localparam int DST_CHIP_ID_W   = 14;
    localparam int DST_X_MSB       = 49;
    localparam int DST_X_W         = 8;
    localparam int DST_Y_MSB       = 41;
    localparam int DST_Y_W         = 8;
    localparam int DST_FBITS_MSB   = 33;
    localparam int DST_FBITS_W     = 4;
    localparam int MSG_LEN_MSB     = 29;
    localparam int MSG_LEN_W       = 22;
    localparam int MSG_TYPE_MSB    = 7;
    localparam int MSG_TYPE_W      = 8;

    // source fields, positions within a wide flit.
    localparam int SRC_CHIP_ID_MSB = 191;
    localparam int SRC_CHIP_ID_W   = 14;
    localparam int SRC_X_MSB       = 177;
    localparam int SRC_X_W         = 8;
    localparam int SRC_Y_MSB       = 169;
    localparam int SRC_Y_W         = 8;
    localparam int SRC_FBITS_MSB   = 161;
    localparam int SRC_FBITS_W     = 4;
    localparam int SRC_FIELDS_W    = SRC_CHIP_ID_W + SRC_X_W + SRC_Y_W + SRC_FBITS_W;

    // source fields land at the top of the misc flit.
    localparam int MISC_SRC_MSB = 63;

    typedef enum logic [1:0] {
        sel_route = 2'd0,
        sel_misc  = 2'd1,
        sel_extra = 2'd2
    } flit_sel_e;

    // number of narrow flits needed for extra_w protocol bits.
    function automatic int extra_flit_count(input int extra_w);
        return (extra_w + NARROW_W - 1) / NARROW_W;
    endfunction

    // index width for the extra flits, at least one bit.
    function automatic int extra_idx_w(input int extra_w);
        int n;
        n = extra_flit_count(extra_w);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

endpackage

//--- hdl/noc_narrow_top.sv
// #########################################################
// wide to narrow header converter with credit flow
// control on both sides.
// #########################################################
module noc_narrow_top #(
    parameter int EXTRA_W     = 96,
    parameter int IN_DEPTH    = 4,
    parameter int OUT_DEPTH   = 4,
    parameter int OUT_CREDITS = 4
) (
     input  logic clk
    ,input  logic rst

    ,input  logic                         in_val
    ,input  noc_narrow_pkg::wide_flit_t   in_data
    ,output logic                         in_credit

    ,output logic                         out_val
    ,output noc_narrow_pkg::narrow_flit_t out_data
    ,input  logic                         out_credit
);
    localparam int IDX_W = noc_narrow_pkg::extra_idx_w(EXTRA_W);

    noc_narrow_pkg::wide_flit_t   in_head;
    logic                         in_empty;
    logic                         in_full;
    logic                         in_pop;
    logic                         out_push;
    logic                         out_full;
    logic                         out_empty;
    logic                         out_pop;
    logic                         hdr_load;
    noc_narrow_pkg::flit_sel_e    flit_sel;
    logic [IDX_W-1:0]             extra_index;
    noc_narrow_pkg::narrow_flit_t narrow_flit;
    noc_narrow_pkg::narrow_flit_t out_head;

    // sender credits keep in_full from ever rising with in_val.
    flit_fifo #(.flit_t(noc_narrow_pkg::wide_flit_t), .DEPTH(IN_DEPTH)) u_in_fifo (
        .clk(clk), .rst(rst), .push(in_val && !in_full), .wdata(in_data), .pop(in_pop),
        .head(in_head), .empty(in_empty), .full(in_full)
    );

    narrow_flit_ctrl #(.EXTRA_W(EXTRA_W)) u_ctrl (
        .clk(clk), .rst(rst), .in_empty(in_empty), .out_full(out_full),
        .in_pop(in_pop), .out_push(out_push), .hdr_load(hdr_load),
        .flit_sel(flit_sel), .extra_index(extra_index)
    );

    hdr_flit_slicer #(.EXTRA_W(EXTRA_W)) u_slicer (
        .clk(clk), .hdr_load(hdr_load), .wide_head(in_head), .flit_sel(flit_sel),
        .extra_index(extra_index), .narrow_flit(narrow_flit)
    );

    flit_fifo #(.flit_t(noc_narrow_pkg::narrow_flit_t), .DEPTH(OUT_DEPTH)) u_out_fifo (
        .clk(clk), .rst(rst), .push(out_push), .wdata(narrow_flit), .pop(out_pop),
        .head(out_head), .empty(out_empty), .full(out_full)
    );

    egress_credit_gate #(.OUT_CREDITS(OUT_CREDITS)) u_gate (
        .clk(clk), .rst(rst), .fifo_empty(out_empty), .fifo_head(out_head),
        .fifo_pop(out_pop), .out_credit(out_credit), .out_val(out_val), .out_data(out_data)
    );

    // one credit back per wide flit consumed.
    always_ff @(posedge clk) begin
        if (rst) begin
            in_credit <= 1'b0;
        end else begin
            in_credit <= in_pop;
        end
    end

endmodule

//--- noc_narrow.f
hdl/noc_narrow_pkg.sv
hdl/flit_fifo.sv
hdl/narrow_flit_ctrl.sv
hdl/hdr_flit_slicer.sv
hdl/egress_credit_gate.sv
hdl/noc_narrow_top.sv
tb/tb_noc_narrow.sv

//--- tb/tb_noc_narrow.sv
// #########################################################
// testbench for the wide to narrow header converter with
// credit models on both sides and a reference flit queue.
// #########################################################
module tb_noc_narrow;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int EXTRA_W      = 96;
    localparam int IN_DEPTH     = 4;
    localparam int OUT_DEPTH    = 4;
    localparam int OUT_CREDITS  = 4;
    localparam int NARROW_W     = 64;
    localparam int N_EXTRA      = (EXTRA_W + NARROW_W - 1) / NARROW_W;
    localparam int FLITS_PER    = 2 + N_EXTRA; // routing, misc, extras.
    localparam int NUM_ENTRIES  = 12;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int WATCHDOG_NS  = NUM_ENTRIES * FLITS_PER * 20 * CLK_PERIOD;

    typedef struct packed {
        logic [13:0]        dst_chip;
        logic [7:0]         dst_x;
        logic [7:0]         dst_y;
        logic [3:0]         dst_fbits;
        logic [21:0]        msg_len;
        logic [7:0]         msg_type;
        logic [13:0]        src_chip;
        logic [7:0]         src_x;
        logic [7:0]         src_y;
        logic [3:0]         src_fbits;
        logic [EXTRA_W-1:0] extra;
        logic [7:0]         gap;
    } entry_t;

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         in_val;
    noc_narrow_pkg::wide_flit_t   in_data;
    logic                         in_credit;
    logic                         out_val;
    noc_narrow_pkg::narrow_flit_t out_data;
    logic                         out_credit = 1'b0;

    entry_t                       tbl [NUM_ENTRIES];
    noc_narrow_pkg::wide_flit_t   wide_tbl [NUM_ENTRIES];
    noc_narrow_pkg::narrow_flit_t exp_q [$];

    int n_loaded        = 0;
    int in_credits      = IN_DEPTH;
    int in_credit_total = 0;
    int out_cred        = OUT_CREDITS; // model of the DUT's credit counter.
    int owed            = 0;
    int hold_cycles     = 0;
    int rx_count        = 0;
    int flit_errors     = 0;
    int count_errors    = 0;
    int other_errors    = 0;

    noc_narrow_top #(
        .EXTRA_W(EXTRA_W),
        .IN_DEPTH(IN_DEPTH),
        .OUT_DEPTH(OUT_DEPTH),
        .OUT_CREDITS(OUT_CREDITS)
    ) DUT (
        .clk(clk), .rst(rst), .in_val(in_val), .in_data(in_data), .in_credit(in_credit),
        .out_val(out_val), .out_data(out_data), .out_credit(out_credit)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_flit(input noc_narrow_pkg::narrow_flit_t got,
                              input noc_narrow_pkg::narrow_flit_t exp, input int idx);
        if (got !== exp) begin
            flit_errors++;
            $display("Fail out_data (flit %0d): got %h expected %h", idx, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string name);
        if (got !== exp) begin
            count_errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    // fields go in the table and reserved bits get random filler.
    task automatic add_entry(
        input logic [13:0] dst_chip, input logic [7:0] dst_x, input logic [7:0] dst_y,
        input logic [3:0] dst_fbits, input logic [21:0] msg_len, input logic [7:0] msg_type,
        input logic [13:0] src_chip, input logic [7:0] src_x, input logic [7:0] src_y,
        input logic [3:0] src_fbits, input logic [EXTRA_W-1:0] extra, input int gap
    );
        noc_narrow_pkg::wide_flit_t w;
        int i;
        for (i = 0; i < 8; i++) begin
            w[i*32 +: 32] = $urandom();
        end
        w[255:192] = {dst_chip, dst_x, dst_y, dst_fbits, msg_len, msg_type};
        w[191:158] = {src_chip, src_x, src_y, src_fbits};
        w[127 -: EXTRA_W] = extra;
        tbl[n_loaded] = {dst_chip, dst_x, dst_y, dst_fbits, msg_len, msg_type,
                         src_chip, src_x, src_y, src_fbits, extra, 8'(gap)};
        wide_tbl[n_loaded] = w;
        n_loaded++;
    endtask

    task automatic load_table();
        add_entry(14'h0001, 8'h02, 8'h03, 4'h4, 22'h00_0000, 8'h11,
                  14'h0005, 8'h06, 8'h07, 4'h8, 96'h0123_4567_89ab_cdef_fedc_ba98, 0);
        add_entry(14'h3fff, 8'hff, 8'hff, 4'hf, 22'h3f_ffff, 8'hff,
                  14'h3fff, 8'hff, 8'hff, 4'hf, 96'hffff_ffff_ffff_ffff_ffff_ffff, 0);
        add_entry(14'h0000, 8'h00, 8'h00, 4'h0, 22'h00_0003, 8'h00,
                  14'h0000, 8'h00, 8'h00, 4'h0, 96'h0, 0);
        add_entry(14'h2a5a, 8'h5a, 8'ha5, 4'h6, 22'h15_5555, 8'h3c,
                  14'h1234, 8'h56, 8'h78, 4'h9, 96'h8000_0000_0000_0000_0000_0001, 3);
        add_entry(14'h0100, 8'h10, 8'h20, 4'h1, 22'h00_0004, 8'h02,
                  14'h0200, 8'h30, 8'h40, 4'h2, 96'hdead_beef_cafe_f00d_0bad_c0de, 0);
        add_entry(14'h1c3a, 8'h7e, 8'h81, 4'ha, 22'h2a_aaaa, 8'h55,
                  14'h03c3, 8'h18, 8'he7, 4'h5, 96'h0000_0000_ffff_ffff_0000_0000, 1);
        add_entry(14'h0fff, 8'h00, 8'hff, 4'h0, 22'h00_0001, 8'h80,
                  14'h3000, 8'hff, 8'h00, 4'hf, 96'h5555_5555_5555_aaaa_aaaa_aaaa, 0);
        add_entry(14'h0abc, 8'h12, 8'h34, 4'h3, 22'h12_3456, 8'h9a,
                  14'h0def, 8'h9a, 8'hbc, 4'hc, 96'h1111_2222_3333_4444_5555_6666, 0);
        add_entry(14'h3210, 8'hfe, 8'hdc, 4'hb, 22'h0f_0f0f, 8'h76,
                  14'h0123, 8'h45, 8'h67, 4'h7, 96'h7777_8888_9999_aaaa_bbbb_cccc, 5);
        add_entry(14'h0033, 8'h44, 8'h55, 4'hd, 22'h00_0002, 8'h66,
                  14'h0777, 8'h88, 8'h99, 4'he, 96'hffff_0000_ffff_0000_ffff_0000, 0);
        add_entry(14'h2000, 8'h01, 8'h80, 4'h7, 22'h20_0000, 8'h01,
                  14'h0001, 8'h80, 8'h01, 4'h1, 96'h0000_0000_0000_0000_8000_0000, 0);
        add_entry(14'h1555, 8'haa, 8'h55, 4'h9, 22'h3c_3c3c, 8'hc3,
                  14'h2aaa, 8'h55, 8'haa, 4'h6, 96'hfedc_ba98_7654_3210_0f1e_2d3c, 2);
    endtask

    // expected narrow flits of one wide header in send order.
    function automatic void model_flits(input entry_t e);
        logic [N_EXTRA*NARROW_W-1:0] padded;
        int k;
        padded = '0;
        padded[N_EXTRA*NARROW_W-1 -: EXTRA_W] = e.extra; // zeros stay at the low end.
        exp_q.push_back({e.dst_chip, e.dst_x, e.dst_y, e.dst_fbits,
                         22'(N_EXTRA + 1), e.msg_type});
        exp_q.push_back({e.src_chip, e.src_x, e.src_y, e.src_fbits, 30'h0});
        for (k = N_EXTRA - 1; k >= 0; k--) begin
            exp_q.push_back(padded[k*NARROW_W +: NARROW_W]);
        end
    endfunction

    // one clock of the sender that collects returned input credits.
    task automatic next_cycle();
        @(negedge clk);
        if (in_credit === 1'b1) begin
            in_credits++;
            in_credit_total++;
            if (in_credits > IN_DEPTH) begin
                other_errors++;
                $display("in_credit pulse with no wide flit outstanding");
            end
        end
    endtask

    // the receiver checks flits and returns output credits after random delays.
    always @(negedge clk) begin
        out_credit = 1'b0;
        if (out_val === 1'b1) begin
            if (out_cred == 0) begin
                other_errors++;
                $display("out_val asserted while the DUT held no output credit");
            end else begin
                out_cred--;
            end
            owed++;
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("narrow flit %h arrived with no flit expected", out_data);
            end else begin
                check_flit(out_data, exp_q.pop_front(), rx_count);
            end
            rx_count++;
        end
        if (hold_cycles > 0) begin
            hold_cycles--;
        end else if ($urandom_range(15) == 0) begin
            hold_cycles = $urandom_range(12, 4); // withhold credits for a while.
        end else if (owed > 0 && $urandom_range(1) == 0) begin
            out_credit = 1'b1;
            owed--;
            out_cred++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns with %0d narrow flits still expected",
                 WATCHDOG_NS, exp_q.size());
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h9ed4_b7cf));
        rst     = 1'b1;
        in_val  = 1'b0;
        in_data = '0;
        load_table();

        repeat (RESET_CYCLES) begin
            next_cycle();
            if (out_val !== 1'b0) begin
                other_errors++;
                $display("out_val not low during reset");
            end
        end
        rst = 1'b0;

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            repeat (tbl[i].gap) next_cycle();
            while (in_credits == 0) begin
                next_cycle();
            end
            in_val  = 1'b1;
            in_data = wide_tbl[i];
            model_flits(tbl[i]);
            in_credits--;
            next_cycle();
            in_val = 1'b0;
        end

        // drain until every flit is seen and its output credit returned.
        while (exp_q.size() != 0 || owed != 0) begin
            next_cycle();
        end
        repeat (OUT_DEPTH + 4) next_cycle();

        check_count(in_credit_total, NUM_ENTRIES, "in_credit pulses");
        check_count(rx_count, NUM_ENTRIES * FLITS_PER, "narrow flits received");

        $display("errors: flit %0d, count %0d, other %0d",
                 flit_errors, count_errors, other_errors);
        if (flit_errors + count_errors + other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
